/* Makefile */
BIN := obj_dir/Vacq_tb

.PHONY: all run clean

all: run

$(BIN): all.f $(wildcard hw/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module acq_tb -f all.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
hw/acq_data_pkg.sv
hw/acq_ctrl_pkg.sv
hw/circ_buf.sv
hw/trig_addr_fifo.sv
hw/readout_cntr.sv
hw/acq_fsm.sv
hw/record_builder.sv
hw/acq_top.sv
dv/acq_properties.sv
dv/acq_checker.sv
dv/acq_tb.sv

/* dv/acq_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_checker #(
    parameter int CBUF_AW = 10
) (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  wire                        acq_enable,
    input  wire                        acq_trig,
    input  acq_data_pkg::sample_pair_t sample_in,
    input  acq_ctrl_pkg::acq_cfg_t     cfg,
    input  wire                        fill_init,
    input  wire  [23:0]                fill_num_init,
    input  acq_data_pkg::acq_rec_t     rec,
    input  wire                        rec_valid,
    input  wire                        acq_idle,
    input  wire                        test_done,    // end of one vector line
    input  wire  [31:0]                exp_recs,
    output logic                       busy,         // records still owed by the dut
    output int                         hdr_errs,
    output int                         data_errs,
    output int                         seq_errs
);

    localparam int         DEPTH    = 2 ** CBUF_AW;
    localparam logic [3:0] HDR_TAG  = 4'h1;
    localparam logic [3:0] DATA_TAG = 4'h2;

    logic [25:0]        model [DEPTH];   // every written pair, earlier sample low
    logic [CBUF_AW-1:0] pend [$];        // trigger addresses not yet answered
    logic [CBUF_AW-1:0] wcount;          // write count modulo the depth
    logic [CBUF_AW-1:0] rd_ptr;          // next pair of the open waveform
    logic               wr_en_m;         // enable one cycle late, like the buffer
    logic               trig_q_m;
    logic [23:0]        fill_m;
    int                 words_left;
    int                 test_recs;
    int                 dis_cnt;         // cycles with enable low

    function automatic logic [127:0] expect_hdr(input logic [CBUF_AW-1:0] addr);
        return {46'd0, cfg.channel_tag, fill_m, cfg.num_bursts, cfg.pre_trig, 16'(addr)};
    endfunction

    // eight lanes of {3'b0, ovr, sample}, earliest sample in lane 0
    function automatic logic [127:0] expect_data(input logic [CBUF_AW-1:0] start);
        logic [127:0] w;
        logic [25:0]  pair;
        int           i;
        w = '0;
        for (i = 0; i < 8; i++) begin
            pair          = model[start + CBUF_AW'(i / 2)];
            w[16*i +: 13] = (i % 2 == 0) ? pair[12:0] : pair[25:13];
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////
    // record comparison

    task automatic check_record();
        logic [CBUF_AW-1:0] addr;
        logic [127:0]       exp_word;
        test_recs++;
        if (rec.tag == HDR_TAG) begin
            if (words_left != 0) begin
                seq_errs++;
                $display("header at %0t cut into a waveform, %0d data words missing",
                         $time, words_left);
            end
            if (pend.size() == 0) begin
                seq_errs++;
                $display("header at %0t without any trigger to answer", $time);
            end else begin
                addr     = pend.pop_front();   // triggers are answered in order
                exp_word = expect_hdr(addr);
                if (rec.payload !== exp_word) begin
                    hdr_errs++;
                    $display("FAIL %0t: header %h, expected %h", $time, rec.payload, exp_word);
                end
                rd_ptr     = addr - cfg.pre_trig[CBUF_AW-1:0];   // wraps with the depth
                words_left = int'(cfg.num_bursts);
            end
        end else if (rec.tag == DATA_TAG) begin
            if (words_left == 0) begin
                seq_errs++;
                $display("data word at %0t outside of any waveform", $time);
            end else begin
                exp_word = expect_data(rd_ptr);
                if (rec.payload !== exp_word) begin
                    data_errs++;
                    $display("FAIL %0t: data %h, expected %h", $time, rec.payload, exp_word);
                end
                rd_ptr = rd_ptr + CBUF_AW'(4);
                words_left--;
                if (words_left == 0)
                    fill_m = fill_m + 24'd1;   // waveform complete
            end
        end else begin
            seq_errs++;
            $display("FAIL %0t: record tag %h is neither header nor data", $time, rec.tag);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // write side model and per-test bookkeeping

    always @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            pend.delete();
            wcount     = '0;
            rd_ptr     = '0;
            wr_en_m    = 1'b0;
            trig_q_m   = 1'b0;
            fill_m     = '0;
            words_left = 0;
            test_recs  = 0;
            dis_cnt    = 0;
            busy       = 1'b0;
            hdr_errs   = 0;
            data_errs  = 0;
            seq_errs   = 0;
        end else begin
            if (rec_valid)
                check_record();          // outputs still hold last cycle's values
            if (wr_en_m) begin
                if (acq_trig && !trig_q_m)
                    pend.push_back(wcount);   // address of the pair written now
                model[wcount] = sample_in;
                wcount        = wcount + 1'b1;
            end
            wr_en_m  = acq_enable;
            trig_q_m = acq_trig;
            if (fill_init)
                fill_m = fill_num_init;
            dis_cnt = acq_enable ? 0 : dis_cnt + 1;
            if (dis_cnt > 4 && pend.size() == 0 && words_left == 0 && !acq_idle) begin
                seq_errs++;
                $display("acq_idle low at %0t although acquisition is off", $time);
            end
            if (test_done) begin
                if (test_recs != exp_recs) begin
                    seq_errs++;
                    $display("FAIL %0t: %0d records in this test, expected %0d",
                             $time, test_recs, exp_recs);
                end
                test_recs = 0;
            end
            busy = (pend.size() != 0) || (words_left != 0);
        end
    end

endmodule

`default_nettype wire

/* dv/acq_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_properties (
    input wire                    adc_clk,
    input wire                    rst_n,
    input wire                    rec_valid,
    input wire                    acq_idle,    // sequencer in ST_IDLE
    input wire                    trig_push,
    input wire                    full,
    input acq_data_pkg::acq_rec_t rec
);

    // idle sequencer never has a record in flight
    a_no_rec_idle: assert property (@(posedge adc_clk) disable iff (!rst_n)
        rec_valid |-> !acq_idle)
        else $error("record valid while the sequencer is idle");

    a_no_push_full: assert property (@(posedge adc_clk) disable iff (!rst_n)
        trig_push |-> !full)
        else $error("trigger pushed into a full address fifo");

    // only two record kinds exist
    a_tag_known: assert property (@(posedge adc_clk) disable iff (!rst_n)
        rec_valid |-> (rec.tag == acq_data_pkg::TAG_HDR || rec.tag == acq_data_pkg::TAG_DATA))
        else $error("record tag is neither header nor data");

    a_quiet_after_reset: assert property (@(posedge adc_clk)
        $rose(rst_n) |-> !rec_valid)
        else $error("record valid right after reset release");

endmodule

bind acq_top acq_properties props_i (
    .adc_clk  (adc_clk),
    .rst_n    (rst_n),
    .rec_valid(rec_valid),
    .acq_idle (acq_idle),
    .trig_push(trig_push),
    .full     (full),
    .rec      (rec)
);

`default_nettype wire

/* dv/acq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_tb;

    localparam int CBUF_AW  = 10;
    localparam int N_TESTS  = 12;
    localparam int N_FIELDS = 8;     // columns per vector line
    localparam int MARGIN   = 200;   // spare cycles on top of the tests

    logic                       adc_clk = 1'b0;
    logic                       rst_n;
    logic                       acq_enable;
    logic                       acq_trig;
    acq_data_pkg::sample_pair_t sample_in;
    acq_ctrl_pkg::acq_cfg_t     cfg;
    logic                       fill_init;
    logic [23:0]                fill_num_init;
    acq_data_pkg::acq_rec_t     rec;
    logic                       rec_valid;
    logic                       acq_idle;

    logic        test_done;
    logic [31:0] exp_recs;
    logic        busy;
    int          hdr_errs;
    int          data_errs;
    int          seq_errs;

    logic [31:0] vec [N_TESTS*N_FIELDS];
    logic [15:0] lfsr      = 16'd21621;
    int          cycle_cnt = 0;
    int          cycle_limit;

    acq_top #(.CBUF_AW(CBUF_AW), .TRIG_DEPTH(4)) dut_i (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .acq_enable   (acq_enable),
        .acq_trig     (acq_trig),
        .sample_in    (sample_in),
        .cfg          (cfg),
        .fill_init    (fill_init),
        .fill_num_init(fill_num_init),
        .rec          (rec),
        .rec_valid    (rec_valid),
        .acq_idle     (acq_idle)
    );

    acq_checker #(.CBUF_AW(CBUF_AW)) chk_i (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .acq_enable   (acq_enable),
        .acq_trig     (acq_trig),
        .sample_in    (sample_in),
        .cfg          (cfg),
        .fill_init    (fill_init),
        .fill_num_init(fill_num_init),
        .rec          (rec),
        .rec_valid    (rec_valid),
        .acq_idle     (acq_idle),
        .test_done    (test_done),
        .exp_recs     (exp_recs),
        .busy         (busy),
        .hdr_errs     (hdr_errs),
        .data_errs    (data_errs),
        .seq_errs     (seq_errs)
    );

    always #50 adc_clk = ~adc_clk;   // 100 ns period

    // taps x^16 + x^14 + x^13 + x^11 with the new bit entering at bit 0
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] field(input int t, input int i);
        return vec[t*N_FIELDS + i];
    endfunction

    // settle, pre-trigger window, trigger train and drain
    function automatic int test_cycles(input int t);
        return field(t, 3) + field(t, 5) * field(t, 6) + 4 * field(t, 4) + 40;
    endfunction

    task automatic skip_cycles(input int n);
        repeat (n) @(posedge adc_clk);
        #1;                                // drive just after the edge
    endtask

    always @(posedge adc_clk) begin : drive_samples
        logic [25:0] bits;
        int          b;
        #1;
        for (b = 0; b < 26; b++) begin
            lfsr    = lfsr_step(lfsr);     // one step per bit
            bits[b] = lfsr[0];
        end
        sample_in = bits;
    end

    always @(posedge adc_clk) begin : watchdog
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never delivered all records", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // one vector line

    task automatic run_test(input int t);
        int i;
        $display("test %0d: enable %0d pre_trig %0d bursts %0d triggers %0d", t,
                 field(t, 0), field(t, 3), field(t, 4), field(t, 5));
        cfg.channel_tag = 12'(field(t, 2));    // only changed while disabled
        cfg.pre_trig    = 16'(field(t, 3));
        cfg.num_bursts  = 14'(field(t, 4));
        fill_num_init   = 24'(field(t, 1));
        fill_init       = 1'b1;
        skip_cycles(1);
        fill_init  = 1'b0;
        acq_enable = 1'(field(t, 0));
        skip_cycles(field(t, 3) + 8);          // fill the pre-trigger window
        for (i = 0; i < field(t, 5); i++) begin
            acq_trig = 1'b1;
            skip_cycles(1);
            acq_trig = 1'b0;
            skip_cycles(field(t, 6) - 1);
        end
        while (busy)
            skip_cycles(1);                    // watchdog covers a stuck DUT
        acq_enable = 1'b0;
        skip_cycles(6);
        exp_recs  = field(t, 7);
        test_done = 1'b1;
        skip_cycles(1);
        test_done = 1'b0;
    endtask

    initial begin
        int t;
        rst_n         = 1'b0;
        acq_enable    = 1'b0;
        acq_trig      = 1'b0;
        sample_in     = '0;
        cfg           = '0;
        fill_init     = 1'b0;
        fill_num_init = '0;
        test_done     = 1'b0;
        exp_recs      = '0;
        $readmemh("dv/acq_vectors.txt", vec);
        cycle_limit = MARGIN + 10;
        for (t = 0; t < N_TESTS; t++)
            cycle_limit += test_cycles(t);
        skip_cycles(10);                       // reset held for 10 cycles
        rst_n = 1'b1;
        skip_cycles(2);
        for (t = 0; t < N_TESTS; t++)
            run_test(t);
        skip_cycles(4);
        $display("errors: header %0d, data %0d, sequence %0d", hdr_errs, data_errs, seq_errs);
        if (hdr_errs + data_errs + seq_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/acq_vectors.txt */
// columns, all hex: enable fill_init channel_tag pre_trig num_bursts
//   trigger_count trigger_spacing expected_records
// spacing is the cycle count between trigger rising edges
1 000000 5A1 0008 0002 1 20 3
1 000100 123 0000 0001 2 0C 4
1 FFFFFE ABC 0010 0004 3 18 F
0 000042 777 0004 0002 3 10 0
1 001000 001 03F0 0001 1 10 2
1 000007 FFF 0020 0010 2 48 22
1 00ABCD 800 0003 0003 3 14 C
0 000000 000 0000 0001 1 0C 0
1 123456 3C3 0100 0040 1 108 41
1 000010 246 0001 0001 3 0C 6
1 000020 135 007F 0008 2 28 12
1 000000 9E7 0200 007C 1 200 7D

/* hw/acq_ctrl_pkg.sv */
`default_nettype none

package acq_ctrl_pkg;

    // readout sequencer states
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,   // acquisition off
        ST_ARMED = 3'd1,   // waiting for a queued trigger
        ST_POP   = 3'd2,   // take trigger address, load read counter
        ST_HDR   = 3'd3,   // send the header word
        ST_READ  = 3'd4    // walk the buffer, one pair per cycle
    } acq_state_t;

    // static acquisition setup, held while enabled
    typedef struct packed {
        logic [11:0] channel_tag;  // copied into every header
        logic [15:0] pre_trig;     // pairs kept ahead of the trigger pair
        logic [13:0] num_bursts;   // data words per waveform
    } acq_cfg_t;                   // 42 bits

endpackage

`default_nettype wire

/* hw/acq_data_pkg.sv */
`default_nettype none

package acq_data_pkg;

    localparam int SMP_W          = 12;  // adc sample width
    localparam int PAIRS_PER_WORD = 4;   // four pairs make one 128-bit data word

    typedef struct packed {
        logic             ovr;  // over-range flag from the adc
        logic [SMP_W-1:0] smp;
    } adc_sample_t;             // 13 bits

    typedef struct packed {
        adc_sample_t s1;        // later sample
        adc_sample_t s0;        // earlier sample sits in the low half
    } sample_pair_t;            // 26 bits

    typedef enum logic [3:0] {
        TAG_HDR  = 4'd1,        // waveform header
        TAG_DATA = 4'd2         // eight samples
    } rec_tag_t;

    typedef struct packed {
        rec_tag_t     tag;
        logic [127:0] payload;
    } acq_rec_t;                // 132 bits into the downstream fifo

    // header word, msb first
    typedef struct packed {
        logic [45:0] pad;
        logic [11:0] channel_tag;
        logic [23:0] fill_num;
        logic [13:0] num_bursts;
        logic [15:0] pre_trig;
        logic [15:0] trig_addr;   // zero-extended buffer address
    } wfm_hdr_t;

    // one 16-bit lane of a data word, lane 0 holds the earliest sample
    typedef struct packed {
        logic [2:0]       pad;
        logic             ovr;
        logic [SMP_W-1:0] smp;
    } data_lane_t;

endpackage

`default_nettype wire

/* hw/acq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_fsm (
    input  wire  adc_clk,
    input  wire  rst_n,
    input  wire  acq_enable,
    input  wire  empty,       // no trigger queued
    input  wire  word_done,
    input  wire  last_word,
    output logic pop,         // take the fifo head
    output logic load,        // load the read counter
    output logic step,        // advance the read address
    output logic shift,       // ram data valid, shift into the builder
    output logic hdr_sel,     // header path in the builder
    output logic emit,        // write a record
    output logic fill_inc,    // waveform finished
    output logic acq_idle
);

    acq_ctrl_pkg::acq_state_t state;
    acq_ctrl_pkg::acq_state_t state_nxt;

    logic word_done_q;  // lines up with the ram read latency
    logic last_q;

    ////////////////////////////////////////////////////////////
    // next state

    always_comb begin
        state_nxt = state;
        unique case (state)
            acq_ctrl_pkg::ST_IDLE: begin
                if (acq_enable)
                    state_nxt = acq_ctrl_pkg::ST_ARMED;
            end
            acq_ctrl_pkg::ST_ARMED: begin
                if (!empty)
                    state_nxt = acq_ctrl_pkg::ST_POP;
                else if (!acq_enable && !word_done_q)  // let the last word out first
                    state_nxt = acq_ctrl_pkg::ST_IDLE;
            end
            acq_ctrl_pkg::ST_POP:
                state_nxt = acq_ctrl_pkg::ST_HDR;
            acq_ctrl_pkg::ST_HDR:
                state_nxt = acq_ctrl_pkg::ST_READ;
            acq_ctrl_pkg::ST_READ: begin
                if (word_done && last_word)
                    state_nxt = acq_ctrl_pkg::ST_ARMED;  // back for the next trigger
            end
            default:
                state_nxt = acq_ctrl_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= acq_ctrl_pkg::ST_IDLE;
            shift       <= 1'b0;
            word_done_q <= 1'b0;
            last_q      <= 1'b0;
        end else begin
            state       <= state_nxt;
            shift       <= step;       // pair appears one cycle after its address
            word_done_q <= word_done;
            last_q      <= word_done && last_word;
        end
    end

    ////////////////////////////////////////////////////////////
    // strobes

    assign pop      = (state == acq_ctrl_pkg::ST_POP);
    assign load     = (state == acq_ctrl_pkg::ST_POP);   // head still valid here
    assign hdr_sel  = (state == acq_ctrl_pkg::ST_POP) || (state == acq_ctrl_pkg::ST_HDR);
    assign step     = (state == acq_ctrl_pkg::ST_READ);
    assign emit     = (state == acq_ctrl_pkg::ST_HDR) || word_done_q;
    assign fill_inc = last_q;                            // with the last data word
    assign acq_idle = (state == acq_ctrl_pkg::ST_IDLE);

endmodule

`default_nettype wire

/* hw/acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_top #(
    parameter int CBUF_AW    = 10,
    parameter int TRIG_DEPTH = 4
) (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  wire                        acq_enable,
    input  wire                        acq_trig,
    input  acq_data_pkg::sample_pair_t sample_in,
    input  acq_ctrl_pkg::acq_cfg_t     cfg,            // static while enabled
    input  wire                        fill_init,
    input  wire  [23:0]                fill_num_init,
    output acq_data_pkg::acq_rec_t     rec,
    output logic                       rec_valid,
    output logic                       acq_idle
);

    acq_data_pkg::sample_pair_t rd_data;
    logic [CBUF_AW-1:0]         rd_addr;
    logic [CBUF_AW-1:0]         wr_addr;
    logic [CBUF_AW-1:0]         head_addr;   // oldest queued trigger
    logic                       trig_push;
    logic                       empty;
    logic                       full;        // watched by the bound checks
    logic                       pop;
    logic                       load;
    logic                       step;
    logic                       word_done;
    logic                       last_word;
    logic                       shift;
    logic                       hdr_sel;
    logic                       emit;
    logic                       fill_inc;

    ////////////////////////////////////////////////////////////
    // write path

    circ_buf #(.CBUF_AW(CBUF_AW)) cbuf_i (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .acq_enable(acq_enable),
        .acq_trig  (acq_trig),
        .sample_in (sample_in),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .wr_addr   (wr_addr),
        .trig_push (trig_push)
    );

    trig_addr_fifo #(.CBUF_AW(CBUF_AW), .TRIG_DEPTH(TRIG_DEPTH)) tfifo_i (
        .adc_clk  (adc_clk),
        .rst_n    (rst_n),
        .push     (trig_push),
        .push_addr(wr_addr),
        .pop      (pop),
        .head_addr(head_addr),
        .empty    (empty),
        .full     (full)
    );

    ////////////////////////////////////////////////////////////
    // readout path

    readout_cntr #(.CBUF_AW(CBUF_AW)) rcnt_i (
        .adc_clk  (adc_clk),
        .rst_n    (rst_n),
        .load     (load),
        .step     (step),
        .trig_addr(head_addr),
        .cfg      (cfg),
        .rd_addr  (rd_addr),
        .word_done(word_done),
        .last_word(last_word)
    );

    acq_fsm fsm_i (
        .adc_clk   (adc_clk),
        .rst_n     (rst_n),
        .acq_enable(acq_enable),
        .empty     (empty),
        .word_done (word_done),
        .last_word (last_word),
        .pop       (pop),
        .load      (load),
        .step      (step),
        .shift     (shift),
        .hdr_sel   (hdr_sel),
        .emit      (emit),
        .fill_inc  (fill_inc),
        .acq_idle  (acq_idle)
    );

    record_builder #(.CBUF_AW(CBUF_AW)) rbld_i (
        .adc_clk      (adc_clk),
        .rst_n        (rst_n),
        .rd_data      (rd_data),
        .shift        (shift),
        .hdr_sel      (hdr_sel),
        .emit         (emit),
        .fill_inc     (fill_inc),
        .fill_init    (fill_init),
        .fill_num_init(fill_num_init),
        .trig_addr    (head_addr),
        .cfg          (cfg),
        .rec          (rec),
        .rec_valid    (rec_valid)
    );

endmodule

`default_nettype wire

/* hw/circ_buf.sv */
`timescale 1ns/1ps
`default_nettype none

module circ_buf #(
    parameter int CBUF_AW = 10                       // buffer depth is 2**CBUF_AW pairs
) (
    input  wire                         adc_clk,
    input  wire                         rst_n,
    input  wire                         acq_enable,  // level from control side
    input  wire                         acq_trig,    // raw trigger level
    input  acq_data_pkg::sample_pair_t  sample_in,
    input  wire [CBUF_AW-1:0]           rd_addr,
    output acq_data_pkg::sample_pair_t  rd_data,     // one cycle after rd_addr
    output logic [CBUF_AW-1:0]          wr_addr,
    output logic                        trig_push    // rising trigger while writing
);

    localparam int DEPTH = 2 ** CBUF_AW;

    acq_data_pkg::sample_pair_t mem [DEPTH];  // dual-port sample ram

    logic wr_en;   // registered acq_enable
    logic trig_q;  // previous trigger level

    ////////////////////////////////////////////////////////////
    // write side control

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en   <= 1'b0;
            trig_q  <= 1'b0;
            wr_addr <= '0;
        end else begin
            wr_en  <= acq_enable;   // one cycle behind the enable
            trig_q <= acq_trig;
            if (wr_en)
                wr_addr <= wr_addr + 1'b1;  // free running, wraps at depth
        end
    end

    // the fifo samples wr_addr on this same edge, so the queued address
    // is the slot the trigger pair lands in
    assign trig_push = acq_trig & ~trig_q & wr_en;

    ////////////////////////////////////////////////////////////
    // sample ram, registered read

    always_ff @(posedge adc_clk) begin
        if (wr_en)
            mem[wr_addr] <= sample_in;
        rd_data <= mem[rd_addr];   // read-before-write on a collision
    end

endmodule

`default_nettype wire

/* hw/readout_cntr.sv */
`timescale 1ns/1ps
`default_nettype none

module readout_cntr #(
    parameter int CBUF_AW = 10
) (
    input  wire                    adc_clk,
    input  wire                    rst_n,
    input  wire                    load,       // start of a waveform
    input  wire                    step,       // one pair read this cycle
    input  wire  [CBUF_AW-1:0]     trig_addr,  // fifo head
    input  acq_ctrl_pkg::acq_cfg_t cfg,
    output logic [CBUF_AW-1:0]     rd_addr,
    output logic                   word_done,  // fourth pair of a word
    output logic                   last_word   // final burst in progress
);

    localparam int PC_W = $clog2(acq_data_pkg::PAIRS_PER_WORD);

    logic [PC_W-1:0] pair_cnt;   // pair within the current data word
    logic [13:0]     burst_cnt;  // data words still to read

    assign word_done = step && (pair_cnt == PC_W'(acq_data_pkg::PAIRS_PER_WORD - 1));
    assign last_word = (burst_cnt == 14'd1);

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr   <= '0;
            pair_cnt  <= '0;
            burst_cnt <= '0;
        end else if (load) begin
            // start pre_trig pairs back, modulo the buffer depth
            rd_addr   <= trig_addr - cfg.pre_trig[CBUF_AW-1:0];
            pair_cnt  <= '0;
            burst_cnt <= cfg.num_bursts;
        end else if (step) begin
            rd_addr  <= rd_addr + 1'b1;
            pair_cnt <= pair_cnt + 1'b1;  // wraps every word
            if (word_done)
                burst_cnt <= burst_cnt - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/record_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module record_builder #(
    parameter int CBUF_AW = 10
) (
    input  wire                        adc_clk,
    input  wire                        rst_n,
    input  acq_data_pkg::sample_pair_t rd_data,
    input  wire                        shift,
    input  wire                        hdr_sel,       // latch address, or pick header on emit
    input  wire                        emit,
    input  wire                        fill_inc,
    input  wire                        fill_init,
    input  wire  [23:0]                fill_num_init,
    input  wire  [CBUF_AW-1:0]         trig_addr,
    input  acq_ctrl_pkg::acq_cfg_t     cfg,
    output acq_data_pkg::acq_rec_t     rec,
    output logic                       rec_valid
);

    localparam int NP = acq_data_pkg::PAIRS_PER_WORD;

    acq_data_pkg::sample_pair_t [NP-1:0] pairs_q;     // wide shift register
    acq_data_pkg::sample_pair_t [NP-1:0] pairs_nxt;   // includes the pair arriving now
    acq_data_pkg::data_lane_t [2*NP-1:0] lanes;
    acq_data_pkg::wfm_hdr_t              hdr;
    logic [CBUF_AW-1:0]                  trig_addr_q;
    logic [23:0]                         fill_num;

    // newest pair enters at the top, the oldest ends in slot 0
    assign pairs_nxt = {rd_data, pairs_q[NP-1:1]};

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            lanes[2*p]   = {3'b000, pairs_nxt[p].s0.ovr, pairs_nxt[p].s0.smp};
            lanes[2*p+1] = {3'b000, pairs_nxt[p].s1.ovr, pairs_nxt[p].s1.smp};
        end
    end

    always_comb begin
        hdr             = '0;
        hdr.channel_tag = cfg.channel_tag;
        hdr.fill_num    = fill_num;
        hdr.num_bursts  = cfg.num_bursts;
        hdr.pre_trig    = cfg.pre_trig;
        hdr.trig_addr   = 16'(trig_addr_q);   // zero-extend
    end

    always_ff @(posedge adc_clk) begin
        if (shift)
            pairs_q <= pairs_nxt;
        if (hdr_sel && !emit)
            trig_addr_q <= trig_addr;    // fifo head before the pop edge
        if (emit)
            rec <= hdr_sel ? {acq_data_pkg::TAG_HDR, 128'(hdr)}
                           : {acq_data_pkg::TAG_DATA, 128'(lanes)};
    end

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= 1'b0;
            fill_num  <= '0;
        end else begin
            rec_valid <= emit;               // single cycle, no back-pressure
            if (fill_init)
                fill_num <= fill_num_init;
            else if (fill_inc)
                fill_num <= fill_num + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hw/trig_addr_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module trig_addr_fifo #(
    parameter int CBUF_AW    = 10,
    parameter int TRIG_DEPTH = 4
) (
    input  wire                adc_clk,
    input  wire                rst_n,
    input  wire                push,
    input  wire  [CBUF_AW-1:0] push_addr,
    input  wire                pop,
    output logic [CBUF_AW-1:0] head_addr,  // valid whenever not empty
    output logic               empty,
    output logic               full
);

    localparam int PTR_W = (TRIG_DEPTH > 1) ? $clog2(TRIG_DEPTH) : 1;
    localparam int CNT_W = $clog2(TRIG_DEPTH + 1);

    logic [CBUF_AW-1:0] mem [TRIG_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               push_ok;     // a push into a full fifo is lost
    logic               pop_ok;

    assign push_ok   = push & ~full;
    assign pop_ok    = pop & ~empty;
    assign empty     = (count == '0);
    assign full      = (count == CNT_W'(TRIG_DEPTH));
    assign head_addr = mem[rd_ptr];  // first word falls through

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= (wr_ptr == PTR_W'(TRIG_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == PTR_W'(TRIG_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push_ok && !pop_ok)
                count <= count + 1'b1;
            else if (pop_ok && !push_ok)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_addr;  // storage, no reset
    end

endmodule

`default_nettype wire
